// File: common/int_pipe_pkg.sv
/*
 * Integer pipeline shared definitions
 * Widths, opcode and ALU encodings, and the records passed between stages
 */

package int_pipe_pkg;

  // ------------------------------------------------
  // Widths and sizes
  // ------------------------------------------------

  // Data path width
  localparam int XLEN = 32;

  // Register index and register count
  localparam int REG_ADDR_W = 5;
  localparam int REG_COUNT  = 32;

  // Issue queue sizing
  localparam int QUEUE_DEPTH = 2;
  localparam int QUEUE_PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

  // ------------------------------------------------
  // Encodings
  // ------------------------------------------------

  // Major opcodes handled by the pipeline
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111
  } opcode_e;

  // ALU functions, PASS_B forwards operand b for lui
  typedef enum logic [3:0] {
    ADD    = 4'd0,
    SUB    = 4'd1,
    SLL    = 4'd2,
    SLT    = 4'd3,
    SLTU   = 4'd4,
    XOR    = 4'd5,
    SRL    = 4'd6,
    SRA    = 4'd7,
    OR     = 4'd8,
    AND    = 4'd9,
    PASS_B = 4'd10
  } alu_op_e;

  // ------------------------------------------------
  // Records between stages
  // ------------------------------------------------

  // Operation in flight from issue to execute, 73 bits
  typedef struct packed {
    alu_op_e               alu_op;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       op_a;
    logic [XLEN-1:0]       op_b;
  } issue_op_t;

  // Writeback result, 37 bits
  typedef struct packed {
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       data;
  } wb_t;

endpackage

// File: execute/alu.sv
/*
 * Integer ALU
 * Purely combinational, one result per ALU function
 */

`timescale 1ns/1ns

module alu (
  input  int_pipe_pkg::alu_op_e         op,
  input  logic [int_pipe_pkg::XLEN-1:0] a,
  input  logic [int_pipe_pkg::XLEN-1:0] b,
  output logic [int_pipe_pkg::XLEN-1:0] result
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // Shifts use only the low five bits of b
  assign shamt = b[4:0];

  // Comparisons for slt and sltu
  assign lt_signed   = ($signed(a) < $signed(b));
  assign lt_unsigned = (a < b);

  always_comb begin
    case (op)
      int_pipe_pkg::ADD:    result = a + b;
      int_pipe_pkg::SUB:    result = a - b;
      int_pipe_pkg::SLL:    result = a << shamt;
      int_pipe_pkg::SLT:    result = {31'b0, lt_signed};
      int_pipe_pkg::SLTU:   result = {31'b0, lt_unsigned};
      int_pipe_pkg::XOR:    result = a ^ b;
      int_pipe_pkg::SRL:    result = a >> shamt;
      // Arithmetic shift keeps the sign bit
      int_pipe_pkg::SRA:    result = $unsigned($signed(a) >>> shamt);
      int_pipe_pkg::OR:     result = a | b;
      int_pipe_pkg::AND:    result = a & b;
      int_pipe_pkg::PASS_B: result = b;
      // Unused encodings
      default:              result = '0;
    endcase
  end

endmodule

// File: execute/execute_stage.sv
/*
 * Execute stage
 * Execute register, ALU and writeback register with hold under back-pressure
 */

`timescale 1ns/1ns

module execute_stage (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    pop_valid,
  input  int_pipe_pkg::issue_op_t pop_op,
  output logic                    pop_ready,
  output logic                    wb_valid,
  output int_pipe_pkg::wb_t       wb,
  input  logic                    wb_ready
);

  logic                          ex_valid;
  int_pipe_pkg::issue_op_t       ex_op;
  logic [int_pipe_pkg::XLEN-1:0] alu_result;
  logic                          wb_free;
  logic                          ex_free;

  // ------------------------------------------------
  // Stage advance
  // ------------------------------------------------

  // Writeback slot empty or retiring this edge
  assign wb_free   = ~wb_valid | wb_ready;
  // Execute slot empty or moving on this edge
  assign ex_free   = ~ex_valid | wb_free;
  assign pop_ready = ex_free;

  // ------------------------------------------------
  // Execute register
  // ------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_valid <= 1'b0;
    end else if (ex_free) begin
      ex_valid <= pop_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_free && pop_valid) begin
      ex_op <= pop_op;
    end
  end

  alu u_alu (
    .op     (ex_op.alu_op),
    .a      (ex_op.op_a),
    .b      (ex_op.op_b),
    .result (alu_result)
  );

  // ------------------------------------------------
  // Writeback register
  // ------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_valid <= 1'b0;
    end else if (wb_free) begin
      wb_valid <= ex_valid;
    end
  end

  // Result captured together with its destination
  always_ff @(posedge clk) begin
    if (wb_free && ex_valid) begin
      wb.rd   <= ex_op.rd;
      wb.data <= alu_result;
    end
  end

endmodule

// File: issue/regfile.sv
/*
 * Integer register file
 * Two asynchronous read ports, one synchronous write port, x0 reads zero
 */

`timescale 1ns/1ns

module regfile (
  input  logic                                clk,
  input  logic                                reset,
  input  logic [int_pipe_pkg::REG_ADDR_W-1:0] raddr0,
  input  logic [int_pipe_pkg::REG_ADDR_W-1:0] raddr1,
  output logic [int_pipe_pkg::XLEN-1:0]       rdata0,
  output logic [int_pipe_pkg::XLEN-1:0]       rdata1,
  input  logic                                wen,
  input  logic [int_pipe_pkg::REG_ADDR_W-1:0] waddr,
  input  logic [int_pipe_pkg::XLEN-1:0]       wdata
);

  logic [int_pipe_pkg::XLEN-1:0] regs [int_pipe_pkg::REG_COUNT];

  // Write port, x0 is never written
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < int_pipe_pkg::REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // Read ports
  assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

endmodule

// File: issue/issue_stage.sv
/*
 * Issue stage
 * Decodes one instruction, checks the scoreboard and pushes operands to the queue
 */

`timescale 1ns/1ns

module issue_stage (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  in_valid,
  input  logic [31:0]                           in_inst,
  output logic                                  in_ready,
  output logic [int_pipe_pkg::REG_ADDR_W-1:0]   raddr0,
  output logic [int_pipe_pkg::REG_ADDR_W-1:0]   raddr1,
  input  logic [int_pipe_pkg::XLEN-1:0]         rdata0,
  input  logic [int_pipe_pkg::XLEN-1:0]         rdata1,
  input  logic                                  retire,
  input  logic [int_pipe_pkg::REG_ADDR_W-1:0]   retire_rd,
  output logic                                  push_valid,
  output int_pipe_pkg::issue_op_t               push_op,
  input  logic                                  push_ready
);

  int_pipe_pkg::opcode_e                 opcode;
  logic [int_pipe_pkg::REG_ADDR_W-1:0]   rd;
  logic [int_pipe_pkg::REG_ADDR_W-1:0]   rs1;
  logic [int_pipe_pkg::REG_ADDR_W-1:0]   rs2;
  logic [2:0]                            funct3;
  logic                                  funct7_b5;
  logic [int_pipe_pkg::XLEN-1:0]         imm_i;
  logic [int_pipe_pkg::XLEN-1:0]         imm_u;
  logic [int_pipe_pkg::XLEN-1:0]         shamt;
  logic                                  is_op;
  logic                                  is_op_imm;
  logic                                  is_lui;
  logic                                  legal;
  logic                                  hazard;
  logic                                  accept;
  int_pipe_pkg::alu_op_e                 alu_op;
  logic [int_pipe_pkg::XLEN-1:0]         op_b;
  logic [int_pipe_pkg::REG_COUNT-1:0]    pending;
  logic [int_pipe_pkg::REG_COUNT-1:0]    set_mask;
  logic [int_pipe_pkg::REG_COUNT-1:0]    clear_mask;

  // ------------------------------------------------
  // Field parsing and immediates
  // ------------------------------------------------

  assign opcode    = int_pipe_pkg::opcode_e'(in_inst[6:0]);
  assign rd        = in_inst[11:7];
  assign funct3    = in_inst[14:12];
  assign rs1       = in_inst[19:15];
  assign rs2       = in_inst[24:20];
  // Selects sub and sra
  assign funct7_b5 = in_inst[30];

  // Sign-extended I immediate
  assign imm_i = {{20{in_inst[31]}}, in_inst[31:20]};
  // Upper immediate, low 12 bits zero
  assign imm_u = {in_inst[31:12], 12'b0};
  assign shamt = {27'b0, in_inst[24:20]};

  assign is_op     = (opcode == int_pipe_pkg::OP);
  assign is_op_imm = (opcode == int_pipe_pkg::OP_IMM);
  assign is_lui    = (opcode == int_pipe_pkg::LUI);
  assign legal     = is_op | is_op_imm | is_lui;

  // ------------------------------------------------
  // Hazard check and handshake
  // ------------------------------------------------

  // lui has no register sources, only OP reads rs2
  assign hazard = ((is_op | is_op_imm) & pending[rs1])
                | (is_op & pending[rs2])
                | (legal & pending[rd]);

  // Never looks at in_valid
  assign in_ready   = push_ready & ~hazard;
  assign accept     = in_valid & in_ready;
  // Unsupported opcodes are swallowed here
  assign push_valid = accept & legal;

  // ------------------------------------------------
  // ALU function decode
  // ------------------------------------------------

  always_comb begin
    alu_op = int_pipe_pkg::ADD;
    if (is_lui) begin
      alu_op = int_pipe_pkg::PASS_B;
    end else begin
      case (funct3)
        3'd0: alu_op = (is_op && funct7_b5) ? int_pipe_pkg::SUB : int_pipe_pkg::ADD;
        3'd1: alu_op = int_pipe_pkg::SLL;
        3'd2: alu_op = int_pipe_pkg::SLT;
        3'd3: alu_op = int_pipe_pkg::SLTU;
        3'd4: alu_op = int_pipe_pkg::XOR;
        3'd5: alu_op = funct7_b5 ? int_pipe_pkg::SRA : int_pipe_pkg::SRL;
        3'd6: alu_op = int_pipe_pkg::OR;
        default: alu_op = int_pipe_pkg::AND;
      endcase
    end
  end

  // ------------------------------------------------
  // Operand selection
  // ------------------------------------------------

  assign raddr0 = rs1;
  assign raddr1 = rs2;

  always_comb begin
    if (is_op) begin
      op_b = rdata1;
    end else if (is_lui) begin
      op_b = imm_u;
    end else if (funct3 == 3'd1 || funct3 == 3'd5) begin
      // Immediate shifts take only the shift amount
      op_b = shamt;
    end else begin
      op_b = imm_i;
    end
  end

  assign push_op.alu_op = alu_op;
  assign push_op.rd     = rd;
  assign push_op.op_a   = is_lui ? '0 : rdata0;
  assign push_op.op_b   = op_b;

  // ------------------------------------------------
  // Scoreboard
  // ------------------------------------------------

  // x0 never becomes pending
  assign set_mask   = (push_valid && rd != '0) ?
                      (int_pipe_pkg::REG_COUNT'(1) << rd) : '0;
  assign clear_mask = retire ? (int_pipe_pkg::REG_COUNT'(1) << retire_rd) : '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      pending <= '0;
    end else begin
      // Same register cannot be set and cleared together, rd stall blocks it
      pending <= (pending & ~clear_mask) | set_mask;
    end
  end

endmodule

// File: logic/issue_queue.sv
/*
 * Issue queue
 * Circular FIFO of issued operations between the issue and execute stages
 */

`timescale 1ns/1ns

module issue_queue (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    push_valid,
  input  int_pipe_pkg::issue_op_t push_op,
  output logic                    push_ready,
  output logic                    pop_valid,
  output int_pipe_pkg::issue_op_t pop_op,
  input  logic                    pop_ready
);

  localparam logic [int_pipe_pkg::QUEUE_PTR_W-1:0] LAST_PTR =
    int_pipe_pkg::QUEUE_PTR_W'(int_pipe_pkg::QUEUE_DEPTH - 1);

  int_pipe_pkg::issue_op_t                mem [int_pipe_pkg::QUEUE_DEPTH];
  logic [int_pipe_pkg::QUEUE_PTR_W-1:0]   wr_ptr;
  logic [int_pipe_pkg::QUEUE_PTR_W-1:0]   rd_ptr;
  logic [int_pipe_pkg::QUEUE_CNT_W-1:0]   count;
  logic                                   do_push;
  logic                                   do_pop;

  // Not full / not empty
  assign push_ready = (count != int_pipe_pkg::QUEUE_CNT_W'(int_pipe_pkg::QUEUE_DEPTH));
  assign pop_valid  = (count != '0);
  assign pop_op     = mem[rd_ptr];

  assign do_push = push_valid & push_ready;
  assign do_pop  = pop_valid & pop_ready;

  // Entry storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_op;
    end
  end

  // Pointers wrap at the last entry
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves count alone
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// File: logic/int_pipe.sv
/*
 * Integer pipeline top level
 * Connects issue stage, issue queue, execute stage and register file
 */

`timescale 1ns/1ns

module int_pipe (
  input  logic              clk,
  input  logic              reset,
  input  logic              in_valid,
  input  logic [31:0]       in_inst,
  output logic              in_ready,
  output logic              wb_valid,
  output int_pipe_pkg::wb_t wb,
  input  logic              wb_ready
);

  logic [int_pipe_pkg::REG_ADDR_W-1:0] raddr0;
  logic [int_pipe_pkg::REG_ADDR_W-1:0] raddr1;
  logic [int_pipe_pkg::XLEN-1:0]       rdata0;
  logic [int_pipe_pkg::XLEN-1:0]       rdata1;
  logic                                push_valid;
  logic                                push_ready;
  int_pipe_pkg::issue_op_t             push_op;
  logic                                pop_valid;
  logic                                pop_ready;
  int_pipe_pkg::issue_op_t             pop_op;
  logic                                retire;

  // Retire strobe shared by register file and scoreboard
  assign retire = wb_valid & wb_ready;

  issue_stage u_issue_stage (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (in_valid),
    .in_inst    (in_inst),
    .in_ready   (in_ready),
    .raddr0     (raddr0),
    .raddr1     (raddr1),
    .rdata0     (rdata0),
    .rdata1     (rdata1),
    .retire     (retire),
    .retire_rd  (wb.rd),
    .push_valid (push_valid),
    .push_op    (push_op),
    .push_ready (push_ready)
  );

  regfile u_regfile (
    .clk    (clk),
    .reset  (reset),
    .raddr0 (raddr0),
    .raddr1 (raddr1),
    .rdata0 (rdata0),
    .rdata1 (rdata1),
    .wen    (retire),
    .waddr  (wb.rd),
    .wdata  (wb.data)
  );

  issue_queue u_issue_queue (
    .clk        (clk),
    .reset      (reset),
    .push_valid (push_valid),
    .push_op    (push_op),
    .push_ready (push_ready),
    .pop_valid  (pop_valid),
    .pop_op     (pop_op),
    .pop_ready  (pop_ready)
  );

  execute_stage u_execute_stage (
    .clk       (clk),
    .reset     (reset),
    .pop_valid (pop_valid),
    .pop_op    (pop_op),
    .pop_ready (pop_ready),
    .wb_valid  (wb_valid),
    .wb        (wb),
    .wb_ready  (wb_ready)
  );

endmodule

// File: testbench/int_pipe_asserts.sv
/*
 * Handshake assertions for the integer pipeline, bound into int_pipe
 */

`timescale 1ns/1ns

module int_pipe_asserts (
  input logic              clk,
  input logic              reset,
  input logic              in_valid,
  input logic [31:0]       in_inst,
  input logic              in_ready,
  input logic              wb_valid,
  input int_pipe_pkg::wb_t wb,
  input logic              wb_ready
);

  // Offered instruction held until taken
  property in_hold_p;
    @(posedge clk) disable iff (reset)
      (in_valid && !in_ready) |=> (in_valid && $stable(in_inst));
  endproperty

  // Result held while the consumer stalls
  property wb_hold_p;
    @(posedge clk) disable iff (reset)
      (wb_valid && !wb_ready) |=> (wb_valid && $stable(wb));
  endproperty

  // Nothing to retire straight out of reset
  property wb_idle_after_reset_p;
    @(posedge clk) reset |=> !wb_valid;
  endproperty

  in_hold_a: assert property (in_hold_p)
    else $error("in_inst changed or in_valid dropped before acceptance");

  wb_hold_a: assert property (wb_hold_p)
    else $error("writeback changed while wb_ready was low");

  wb_idle_after_reset_a: assert property (wb_idle_after_reset_p)
    else $error("wb_valid high in the cycle after reset");

endmodule

// File: testbench/int_pipe_tb.sv
/*
 * Testbench for the integer pipeline
 * Random instruction stream with back-pressure, checked against a reference model
 */

`timescale 1ns/1ns

module int_pipe_tb;

  localparam int NUM_INSTS      = 1500;
  localparam int TIMEOUT_CYCLES = 40 * NUM_INSTS;
  localparam int RESET_CYCLES   = 5;

  // Major opcodes as the ISA encodes them
  localparam logic [6:0] OPC_OP     = 7'h33;
  localparam logic [6:0] OPC_OP_IMM = 7'h13;
  localparam logic [6:0] OPC_LUI    = 7'h37;

  logic              clk;
  logic              reset;
  logic              in_valid;
  logic [31:0]       in_inst;
  logic              in_ready;
  logic              wb_valid;
  int_pipe_pkg::wb_t wb;
  logic              wb_ready;

  // Reference model state
  logic [31:0] model_regs [32];
  logic [36:0] expect_q [$];
  logic [4:0]  recent_rd [3];
  logic [36:0] expected;
  logic [31:0] rand_state;
  logic        offer_taken;
  int          sent;
  int          stall_left;
  int          cycle_count = 0;

  int_pipe uut (
    .clk      (clk),
    .reset    (reset),
    .in_valid (in_valid),
    .in_inst  (in_inst),
    .in_ready (in_ready),
    .wb_valid (wb_valid),
    .wb       (wb),
    .wb_ready (wb_ready)
  );

  bind int_pipe int_pipe_asserts u_asserts (
    .clk      (clk),
    .reset    (reset),
    .in_valid (in_valid),
    .in_inst  (in_inst),
    .in_ready (in_ready),
    .wb_valid (wb_valid),
    .wb       (wb),
    .wb_ready (wb_ready)
  );

  always begin
    #5 clk = ~clk;
  end

  // --------------------------------------------------
  // Random source and instruction generation
  // --------------------------------------------------

  // 32-bit xorshift
  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rand_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rand_state = x;
    return x;
  endfunction

  // Half the sources name one of the last three destinations
  function automatic logic [4:0] pick_src();
    logic [31:0] r;
    logic [4:0]  src;
    r = next_rand();
    src = r[20:16];
    if (r[8]) begin
      case (r[1:0])
        2'd0: src = recent_rd[0];
        2'd1: src = recent_rd[1];
        default: src = recent_rd[2];
      endcase
    end
    return src;
  endfunction

  function automatic logic [31:0] make_inst();
    logic [31:0] r;
    logic [31:0] u;
    logic [31:0] inst;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    logic [6:0]  opc;
    r   = next_rand();
    u   = next_rand();
    // Roughly one in sixteen writes x0
    rd  = (r[7:4] == 4'd0) ? 5'd0 : r[12:8];
    rs1 = pick_src();
    rs2 = pick_src();
    f3  = r[15:13];
    // Alternate form only for sub and sra
    f7  = (r[16] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
    imm = r[28:17];
    if (r[3:0] < 4'd6) begin
      inst = {f7, rs2, rs1, f3, rd, OPC_OP};
    end else if (r[3:0] < 4'd12) begin
      // Immediate shifts carry a legal upper field
      if (f3 == 3'd1 || f3 == 3'd5) begin
        imm = {f7, imm[4:0]};
      end
      inst = {imm, rs1, f3, rd, OPC_OP_IMM};
    end else if (r[3:0] < 4'd14) begin
      inst = {u[19:0], rd, OPC_LUI};
    end else begin
      opc = u[6:0];
      if (opc == OPC_OP || opc == OPC_OP_IMM || opc == OPC_LUI) begin
        opc = 7'h0b;
      end
      inst = {imm, rs1, f3, rd, opc};
    end
    return inst;
  endfunction

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------

  function automatic logic [31:0] reference_result(input logic [31:0] inst);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [4:0]  sh;
    a = model_regs[inst[19:15]];
    // Register operand for OP and sign-extended immediate otherwise
    if (inst[6:0] == OPC_OP) begin
      b = model_regs[inst[24:20]];
    end else begin
      b = {{20{inst[31]}}, inst[31:20]};
    end
    sh = b[4:0];
    case (inst[14:12])
      3'd0: begin
        if (inst[6:0] == OPC_OP && inst[30]) begin
          res = a - b;
        end else begin
          res = a + b;
        end
      end
      3'd1: res = a << sh;
      3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: res = (a < b) ? 32'd1 : 32'd0;
      3'd4: res = a ^ b;
      3'd5: begin
        if (inst[30]) begin
          res = $signed(a) >>> sh;
        end else begin
          res = a >> sh;
        end
      end
      3'd6: res = a | b;
      default: res = a & b;
    endcase
    // lui ignores the registers
    if (inst[6:0] == OPC_LUI) begin
      res = {inst[31:12], 12'h000};
    end
    return res;
  endfunction

  // Model registers update at once since results land in acceptance order
  task automatic update_model(input logic [31:0] inst);
    logic [31:0] res;
    logic [6:0]  opc;
    opc = inst[6:0];
    if (opc == OPC_OP || opc == OPC_OP_IMM || opc == OPC_LUI) begin
      res = reference_result(inst);
      if (inst[11:7] != 5'd0) begin
        model_regs[inst[11:7]] = res;
      end
      expect_q.push_back({inst[11:7], res});
      recent_rd[2] = recent_rd[1];
      recent_rd[1] = recent_rd[0];
      recent_rd[0] = inst[11:7];
    end
  endtask

  // --------------------------------------------------
  // Checks, sampling and driving
  // --------------------------------------------------

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s got %h, expected %h", $time, what, got, exp);
      $display("*** TEST FAILED ***");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  // Sampled at the falling edge when the handshakes have settled
  task automatic observe_cycle();
    offer_taken = in_valid && in_ready;
    if (wb_valid && wb_ready) begin
      // Retirement with nothing expected
      check_value("result expected", 64'(expect_q.size() != 0), 64'd1);
      expected = expect_q.pop_front();
      check_value("writeback rd and data", 64'({wb.rd, wb.data}), 64'(expected));
    end
    if (offer_taken) begin
      update_model(in_inst);
      sent++;
    end
  endtask

  task automatic drive_inputs();
    logic [31:0] r;
    r = next_rand();
    // Offer held until taken
    if (!in_valid || offer_taken) begin
      if (sent < NUM_INSTS && r[2:0] != 3'd0) begin
        in_valid = 1'b1;
        in_inst  = make_inst();
      end else begin
        in_valid = 1'b0;
      end
    end
    // Occasional long stalls on the writeback side
    if (stall_left > 0) begin
      stall_left--;
      wb_ready = 1'b0;
    end else if (r[10:5] == 6'd0) begin
      stall_left = 8 + int'(r[15:11]);
      wb_ready   = 1'b0;
    end else begin
      wb_ready = (r[17:16] != 2'd0);
    end
  endtask

  // Run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("*** TEST FAILED ***");
      $fatal(1, "Simulation stopped by the timeout");
    end
  end

  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    in_valid    = 1'b0;
    in_inst     = 32'h0;
    wb_ready    = 1'b0;
    rand_state  = 32'd96980;
    offer_taken = 1'b0;
    sent        = 0;
    stall_left  = 0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = 32'h0;
    end
    for (int i = 0; i < 3; i++) begin
      recent_rd[i] = 5'd0;
    end

    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;
    @(negedge clk);
    check_value("wb_valid after reset", 64'(wb_valid), 64'd0);
    check_value("in_ready after reset", 64'(in_ready), 64'd1);
    @(posedge clk);
    #1;

    // Main stream
    while (sent < NUM_INSTS || expect_q.size() != 0) begin
      drive_inputs();
      @(negedge clk);
      observe_cycle();
      @(posedge clk);
      #1;
    end
    in_valid = 1'b0;
    wb_ready = 1'b1;

    // Nothing may follow the last result
    repeat (10) begin
      @(negedge clk);
      check_value("writeback after the last result", 64'(wb_valid), 64'd0);
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// File: list.f
common/int_pipe_pkg.sv
execute/alu.sv
execute/execute_stage.sv
issue/regfile.sv
issue/issue_stage.sv
logic/issue_queue.sv
logic/int_pipe.sv
testbench/int_pipe_asserts.sv
testbench/int_pipe_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the int_pipe testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert -f list.f --top-module int_pipe_tb -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/Vint_pipe_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q '^\*\*\* TEST PASSED \*\*\*$' "$LOG"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see $LOG"
  exit 1
fi
